/* include/id_stage_config.svh */
`ifndef ID_STAGE_CONFIG_SVH
`define ID_STAGE_CONFIG_SVH

`define ID_XLEN        32 // data and instruction width
`define ID_REG_COUNT   32
`define ID_REG_ADDR_W  5
`define ID_OPCODE_W    6
`define ID_FUNC_W      6
`define ID_IMM_W       16 // I-type immediate
`define ID_OFFSET_W    26 // J-type offset
`define ID_SPARE_W     10 // R-type bits 15:6, not decoded
`define ID_IMM_MODE_W  2

`define OP_LW      6'b000010
`define OP_SW      6'b001010
`define OP_ADDI    6'b010000
`define OP_SUBI    6'b010010
`define OP_ANDI    6'b010100
`define OP_ORI     6'b010101
`define OP_XORI    6'b010110
`define OP_SLTI    6'b011010 // start of signed imm compares
`define OP_SNEI    6'b011111 // end, sgti/sgei/seqi/slei in between
`define OP_BEQZ    6'b100000
`define OP_BNEZ    6'b100001
`define OP_J       6'b100100
`define OP_R_TYPE  6'b110000

`define FN_ADD     6'b000001
`define FN_SUB     6'b000011
`define FN_AND     6'b000101
`define FN_OR      6'b000110
`define FN_XOR     6'b000111
`define FN_SLT     6'b001011 // start of reg compares
`define FN_SNE     6'b010000 // end, sgt/sle/sge/seq in between

`define IMM_ZERO16   2'd0 // imm16 zero-extended
`define IMM_SIGNMAG  2'd1 // imm16 in sign-magnitude
`define IMM_ZERO26   2'd2 // jump offset zero-extended

`endif

/* rtl/id_stage_pkg.sv */
`include "id_stage_config.svh"

package id_stage_pkg;

  // R-type view, rs1 op rs2
  typedef struct packed {
    logic [`ID_OPCODE_W-1:0]   opcode;
    logic [`ID_REG_ADDR_W-1:0] rs1;
    logic [`ID_REG_ADDR_W-1:0] rs2;
    logic [`ID_SPARE_W-1:0]    spare;  // upper func bits, always zero here
    logic [`ID_FUNC_W-1:0]     func;
  } r_fields_t;

  // I-type view, rd_rs2 is the dest for alu ops and the store source for sw
  typedef struct packed {
    logic [`ID_OPCODE_W-1:0]   opcode;
    logic [`ID_REG_ADDR_W-1:0] rs1;
    logic [`ID_REG_ADDR_W-1:0] rd_rs2;
    logic [`ID_IMM_W-1:0]      imm16;
  } i_fields_t;

  // J-type view
  typedef struct packed {
    logic [`ID_OPCODE_W-1:0] opcode;
    logic [`ID_OFFSET_W-1:0] offset;
  } j_fields_t;

  // same word, three decodings, opcode lands in the same bits in all
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
    j_fields_t j;
  } instr_word_t;

endpackage

/* rtl/decode_ctrl_if.sv */
`include "id_stage_config.svh"

interface decode_ctrl_if;

  logic                      load_a;        // A register enable
  logic                      load_b;        // B register enable
  logic                      load_imm;      // IMM register enable
  logic                      a_signmag;     // rs1 to sign-magnitude
  logic                      b_signmag;     // rs2 to sign-magnitude
  logic                      flip_b_sign;   // sub turns into add
  logic [`ID_IMM_MODE_W-1:0] imm_mode;      // immediate extension kind
  logic                      flip_imm_sign; // subi turns into addi

  modport classifier (
    output load_a, load_b, load_imm, a_signmag, b_signmag, flip_b_sign,
    output imm_mode, flip_imm_sign
  );

  modport operand (
    input load_a, load_b, load_imm, a_signmag, b_signmag, flip_b_sign,
    input imm_mode, flip_imm_sign
  );

endinterface

/* rtl/register_file.sv */
`include "id_stage_config.svh"

module register_file (
  input  logic                      clock2,
  input  logic                      reset2,     // async, active low
  input  logic                      write_en,
  input  logic [`ID_REG_ADDR_W-1:0] write_addr,
  input  logic [`ID_XLEN-1:0]       write_data,
  input  logic [`ID_REG_ADDR_W-1:0] rs1_addr,
  input  logic [`ID_REG_ADDR_W-1:0] rs2_addr,
  output logic [`ID_XLEN-1:0]       rs1_data,
  output logic [`ID_XLEN-1:0]       rs2_data
);

  logic [`ID_XLEN-1:0] regs [`ID_REG_COUNT]; // r0 stays zero
  logic                write_ok;             // write to a real register

  assign write_ok = write_en && (write_addr != '0); // r0 is read-only

  always_ff @(posedge clock2 or negedge reset2)
  begin
    if (!reset2)
    begin
      for (int i = 0; i < `ID_REG_COUNT; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (write_ok)
    begin
      regs[write_addr] <= write_data; // visible from the next cycle
    end
  end

  // no bypass, a same-cycle read of the written register gets the old word
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

endmodule

/* rtl/instr_classifier.sv */
`include "id_stage_config.svh"

module instr_classifier (
  input  id_stage_pkg::instr_word_t instr,
  decode_ctrl_if.classifier         ctrl
);

  logic [`ID_OPCODE_W-1:0] opcode;
  logic [`ID_FUNC_W-1:0]   func;
  logic                    signed_imm_op; // a and imm in sign-magnitude
  logic                    logic_imm_op;  // raw a, zero-extended imm
  logic                    add_fn;        // add or sub
  logic                    raw_fn;        // logic ops and compares

  assign opcode = instr.i.opcode;
  assign func   = instr.r.func;

  assign signed_imm_op = (opcode == `OP_LW) || (opcode == `OP_ADDI) ||
                         (opcode == `OP_SUBI) || (opcode == `OP_SW) ||
                         (opcode inside {[`OP_SLTI:`OP_SNEI]}); // slti..snei

  assign logic_imm_op = (opcode == `OP_ANDI) || (opcode == `OP_ORI) ||
                        (opcode == `OP_XORI) || (opcode == `OP_BEQZ) ||
                        (opcode == `OP_BNEZ); // branches compare raw rs1 to zero

  assign add_fn = (func == `FN_ADD) || (func == `FN_SUB);

  assign raw_fn = (func == `FN_AND) || (func == `FN_OR) || (func == `FN_XOR) ||
                  (func inside {[`FN_SLT:`FN_SNE]}); // slt..sne

  always_comb
  begin
    ctrl.load_a        = 1'b0; // unknown codes load nothing
    ctrl.load_b        = 1'b0;
    ctrl.load_imm      = 1'b0;
    ctrl.a_signmag     = 1'b0;
    ctrl.b_signmag     = 1'b0;
    ctrl.flip_b_sign   = 1'b0;
    ctrl.imm_mode      = `IMM_ZERO16;
    ctrl.flip_imm_sign = 1'b0;

    if (signed_imm_op)
    begin
      ctrl.load_a        = 1'b1;
      ctrl.load_imm      = 1'b1;
      ctrl.a_signmag     = 1'b1;
      ctrl.imm_mode      = `IMM_SIGNMAG;
      ctrl.flip_imm_sign = (opcode == `OP_SUBI); // a - imm as a + (-imm)
      ctrl.load_b        = (opcode == `OP_SW);   // store data, raw
    end
    else if (logic_imm_op)
    begin
      ctrl.load_a   = 1'b1;
      ctrl.load_imm = 1'b1; // zero16 from default
    end
    else if (opcode == `OP_J)
    begin
      ctrl.load_imm = 1'b1; // a, b hold
      ctrl.imm_mode = `IMM_ZERO26;
    end
    else if (opcode == `OP_R_TYPE)
    begin
      if (add_fn)
      begin
        ctrl.load_a      = 1'b1;
        ctrl.load_b      = 1'b1;
        ctrl.a_signmag   = 1'b1;
        ctrl.b_signmag   = 1'b1;
        ctrl.flip_b_sign = (func == `FN_SUB); // ex stage only adds
      end
      else if (raw_fn)
      begin
        ctrl.load_a = 1'b1;
        ctrl.load_b = 1'b1;
      end
    end
  end

endmodule

/* rtl/operand_stage.sv */
`include "id_stage_config.svh"

module operand_stage (
  input  logic                      clock2,
  input  logic                      reset2,   // async, active low
  input  id_stage_pkg::instr_word_t instr,
  input  logic [`ID_XLEN-1:0]       npc,
  input  logic [`ID_XLEN-1:0]       rs1_data,
  input  logic [`ID_XLEN-1:0]       rs2_data,
  decode_ctrl_if.operand            ctrl,
  output logic [`ID_XLEN-1:0]       ir_q,     // id/ex pipeline registers
  output logic [`ID_XLEN-1:0]       npc_q,
  output logic [`ID_XLEN-1:0]       a_q,
  output logic [`ID_XLEN-1:0]       b_q,
  output logic [`ID_XLEN-1:0]       imm_q
);

  localparam int IMM_PAD = `ID_XLEN - `ID_IMM_W;    // zero bits above imm16
  localparam int OFS_PAD = `ID_XLEN - `ID_OFFSET_W; // zero bits above offset

  logic [`ID_XLEN-1:0]  a_form;
  logic [`ID_XLEN-1:0]  b_conv;   // b before the sign flip
  logic [`ID_XLEN-1:0]  b_form;
  logic [`ID_IMM_W-1:0] imm16;
  logic [`ID_IMM_W-1:0] imm_neg;  // two's negation of imm16
  logic [`ID_XLEN-1:0]  imm_signed;
  logic [`ID_XLEN-1:0]  imm_ext;  // imm before the sign flip
  logic [`ID_XLEN-1:0]  imm_form;

  // two's complement to sign-magnitude, positive words pass unchanged
  function automatic logic [`ID_XLEN-1:0] sign_mag(input logic [`ID_XLEN-1:0] x);
    logic [`ID_XLEN-1:0] neg;
    neg = ~x + 1'b1;
    if (x[`ID_XLEN-1])
      return {1'b1, neg[`ID_XLEN-2:0]};
    else
      return x;
  endfunction

  assign a_form = ctrl.a_signmag ? sign_mag(rs1_data) : rs1_data;
  assign b_conv = ctrl.b_signmag ? sign_mag(rs2_data) : rs2_data;
  assign b_form = {b_conv[`ID_XLEN-1] ^ ctrl.flip_b_sign, b_conv[`ID_XLEN-2:0]};

  assign imm16   = instr.i.imm16;
  assign imm_neg = ~imm16 + 1'b1;

  // sign on top, magnitude in the low 15 bits
  assign imm_signed = imm16[`ID_IMM_W-1] ?
                      {1'b1, {IMM_PAD{1'b0}}, imm_neg[`ID_IMM_W-2:0]} :
                      {{IMM_PAD{1'b0}}, imm16};

  always_comb
  begin
    case (ctrl.imm_mode)
      `IMM_SIGNMAG: imm_ext = imm_signed;
      `IMM_ZERO16:  imm_ext = {{IMM_PAD{1'b0}}, imm16};
      `IMM_ZERO26:  imm_ext = {{OFS_PAD{1'b0}}, instr.j.offset};
      default:      imm_ext = '0; // unused code
    endcase
  end

  assign imm_form = {imm_ext[`ID_XLEN-1] ^ ctrl.flip_imm_sign, imm_ext[`ID_XLEN-2:0]};

  always_ff @(posedge clock2 or negedge reset2)
  begin
    if (!reset2)
    begin
      ir_q  <= '0;
      npc_q <= '0;
      a_q   <= '0;
      b_q   <= '0;
      imm_q <= '0;
    end
    else
    begin
      ir_q  <= instr;  // always follows the instruction
      npc_q <= npc;
      if (ctrl.load_a)
        a_q <= a_form; // otherwise hold
      if (ctrl.load_b)
        b_q <= b_form;
      if (ctrl.load_imm)
        imm_q <= imm_form;
    end
  end

endmodule

/* rtl/id_stage.sv */
`include "id_stage_config.svh"

module id_stage (
  input  logic                      clock2,
  input  logic                      reset2,       // async, active low
  input  logic [`ID_XLEN-1:0]       npc_in2,
  input  logic [`ID_XLEN-1:0]       inst_in2,
  input  logic                      reg_write_en, // write-back port
  input  logic [`ID_REG_ADDR_W-1:0] reg_add_in,
  input  logic [`ID_XLEN-1:0]       reg_data_in,
  output logic [`ID_XLEN-1:0]       irout2,
  output logic [`ID_XLEN-1:0]       aout2,
  output logic [`ID_XLEN-1:0]       bout2,
  output logic [`ID_XLEN-1:0]       imout2,
  output logic [`ID_XLEN-1:0]       npcout2
);

  import id_stage_pkg::*;

  instr_word_t         instr;    // inst_in2 seen through the field views
  logic [`ID_XLEN-1:0] rs1_data;
  logic [`ID_XLEN-1:0] rs2_data;

  assign instr = instr_word_t'(inst_in2);

  decode_ctrl_if ctrl_if ();

  register_file register_file_i (
    .clock2     (clock2),
    .reset2     (reset2),
    .write_en   (reg_write_en),
    .write_addr (reg_add_in),
    .write_data (reg_data_in),
    .rs1_addr   (instr.r.rs1),
    .rs2_addr   (instr.r.rs2),   // same bits as rd_rs2 of I-type
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data)
  );

  instr_classifier instr_classifier_i (
    .instr (instr),
    .ctrl  (ctrl_if.classifier)
  );

  operand_stage operand_stage_i (
    .clock2   (clock2),
    .reset2   (reset2),
    .instr    (instr),
    .npc      (npc_in2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .ctrl     (ctrl_if.operand),
    .ir_q     (irout2),
    .npc_q    (npcout2),
    .a_q      (aout2),
    .b_q      (bout2),
    .imm_q    (imout2)
  );

endmodule

/* dv/id_stage_properties.sv */
`include "id_stage_config.svh"

module id_stage_properties (
  input logic                clock2,
  input logic                reset2,
  input logic [`ID_XLEN-1:0] inst_in2,
  input logic [`ID_XLEN-1:0] npc_in2,
  input logic [`ID_XLEN-1:0] irout2,
  input logic [`ID_XLEN-1:0] aout2,
  input logic [`ID_XLEN-1:0] bout2,
  input logic [`ID_XLEN-1:0] imout2,
  input logic [`ID_XLEN-1:0] npcout2
);

  logic [`ID_OPCODE_W-1:0] opcode;
  logic                    zero16_op;    // imm16 zero-extended
  logic                    outputs_zero;

  assign opcode = inst_in2[`ID_XLEN-1 -: `ID_OPCODE_W];

  assign zero16_op = (opcode == `OP_ANDI) || (opcode == `OP_ORI) ||
                     (opcode == `OP_XORI) || (opcode == `OP_BEQZ) ||
                     (opcode == `OP_BNEZ);

  assign outputs_zero = (irout2 == '0) && (npcout2 == '0) && (aout2 == '0) &&
                        (bout2 == '0) && (imout2 == '0);

  // ir and npc always load
  ir_npc_follow: assert property (@(posedge clock2) disable iff (!reset2)
    $past(reset2) |-> (irout2 == $past(inst_in2)) && (npcout2 == $past(npc_in2)))
    else $error("irout2 or npcout2 differs from the previous cycle's inputs");

  zero_after_reset: assert property (@(posedge clock2)
    $rose(reset2) |-> outputs_zero)
    else $error("outputs not zero in the first cycle after reset");

  jump_offset_zext: assert property (@(posedge clock2) disable iff (!reset2)
    ($past(reset2) && ($past(opcode) == `OP_J)) |-> (imout2[`ID_XLEN-1:`ID_OFFSET_W] == '0))
    else $error("imout2 not zero-extended after a jump");

  logic_imm_zext: assert property (@(posedge clock2) disable iff (!reset2)
    ($past(reset2) && $past(zero16_op)) |-> (imout2[`ID_XLEN-1:`ID_IMM_W] == '0))
    else $error("imout2 not zero-extended after a logical immediate op");

endmodule

bind id_stage id_stage_properties id_stage_properties_i (
  .clock2   (clock2),
  .reset2   (reset2),
  .inst_in2 (inst_in2),
  .npc_in2  (npc_in2),
  .irout2   (irout2),
  .aout2    (aout2),
  .bout2    (bout2),
  .imout2   (imout2),
  .npcout2  (npcout2)
);

/* dv/id_stage_tb.sv */
`include "id_stage_config.svh"

module id_stage_tb;

  localparam int FIELDS       = 10;                   // words per vector line
  localparam int MAX_VECTORS  = 64;                   // loop limit for the stimulus
  localparam int MEM_WORDS    = FIELDS * MAX_VECTORS;
  localparam int CLK_HALF     = 20;                   // period 40
  localparam int DRIVE_DLY    = 2;                    // input skew after the edge
  localparam int RESET_CYCLES = 5;

  logic                      clock2;
  logic                      reset2;
  logic [`ID_XLEN-1:0]       npc_in2;
  logic [`ID_XLEN-1:0]       inst_in2;
  logic                      reg_write_en;
  logic [`ID_REG_ADDR_W-1:0] reg_add_in;
  logic [`ID_XLEN-1:0]       reg_data_in;
  logic [`ID_XLEN-1:0]       irout2;
  logic [`ID_XLEN-1:0]       aout2;
  logic [`ID_XLEN-1:0]       bout2;
  logic [`ID_XLEN-1:0]       imout2;
  logic [`ID_XLEN-1:0]       npcout2;

  logic [`ID_XLEN-1:0] vec_mem [MEM_WORDS]; // raw words of the testdata file
  int                  vec_count;           // vectors applied so far

  id_stage id_stage_i (
    .clock2       (clock2),
    .reset2       (reset2),
    .npc_in2      (npc_in2),
    .inst_in2     (inst_in2),
    .reg_write_en (reg_write_en),
    .reg_add_in   (reg_add_in),
    .reg_data_in  (reg_data_in),
    .irout2       (irout2),
    .aout2        (aout2),
    .bout2        (bout2),
    .imout2       (imout2),
    .npcout2      (npcout2)
  );

  initial
  begin
    clock2 = 1'b0;
    forever #CLK_HALF clock2 = ~clock2;
  end

  // fail message, then stop the run
  task automatic abort_run(input string what);
    $display("Done: errors found");
    $fatal(1, what);
  endtask

  task automatic check_word(input string name, input logic [`ID_XLEN-1:0] got,
                            input logic [`ID_XLEN-1:0] expected);
    assert (got == expected)
    else
    begin
      $display("** Error at time %0t: %s is %h, expected %h", $time, name, got, expected);
      abort_run({name, " mismatch"});
    end
  endtask

  // words past the data keep the fill, which never looks like a write enable
  task automatic load_vectors();
    for (int k = 0; k < MEM_WORDS; k++)
    begin
      vec_mem[k] = ~k; // unique per address
    end
    $readmemh("dv/id_stage_testdata.txt", vec_mem);
    if (vec_mem[0] > 32'd1)
      abort_run("testdata file is missing or holds no vectors");
  endtask

  // end marker is a first word other than 0 or 1
  function automatic bit at_end_of_data(input int idx);
    if (idx >= MAX_VECTORS)
      return 1'b0; // let the loop limit catch it
    return vec_mem[idx * FIELDS] > 32'd1;
  endfunction

  // called at edge + DRIVE_DLY, returns at the next edge + DRIVE_DLY
  task automatic apply_vector(input int idx);
    int base;
    base = idx * FIELDS;
    reg_write_en = vec_mem[base][0];
    reg_add_in   = vec_mem[base + 1][`ID_REG_ADDR_W-1:0];
    reg_data_in  = vec_mem[base + 2];
    inst_in2     = vec_mem[base + 3];
    npc_in2      = vec_mem[base + 4];
    @(posedge clock2);
    #1; // outputs settled, next drive not yet
    check_word("irout2", irout2, vec_mem[base + 5]);
    check_word("npcout2", npcout2, vec_mem[base + 6]);
    check_word("aout2", aout2, vec_mem[base + 7]);
    check_word("bout2", bout2, vec_mem[base + 8]);
    check_word("imout2", imout2, vec_mem[base + 9]);
    #(DRIVE_DLY - 1);
  endtask

  initial
  begin
    reset2       = 1'b0;
    npc_in2      = '0;
    inst_in2     = '0;
    reg_write_en = 1'b0;
    reg_add_in   = '0;
    reg_data_in  = '0;
    vec_count    = 0;

    load_vectors();

    repeat (RESET_CYCLES) @(posedge clock2);
    #1;
    check_word("irout2", irout2, '0); // everything cleared by reset
    check_word("npcout2", npcout2, '0);
    check_word("aout2", aout2, '0);
    check_word("bout2", bout2, '0);
    check_word("imout2", imout2, '0);
    #(DRIVE_DLY - 1);
    reset2 = 1'b1;

    while (!at_end_of_data(vec_count))
    begin
      if (vec_count >= MAX_VECTORS)
        abort_run("stimulus loop reached its vector limit without an end of data");
      else
      begin
        apply_vector(vec_count);
        vec_count++;
      end
    end

    $display("applied %0d vectors", vec_count);
    $display("Done: no errors");
    $finish;
  end

endmodule

/* dv/id_stage_testdata.txt */
// columns: we addr wdata inst npc, then expected ir npc a b imm after the next edge
// all hex, one vector per line, held operands repeat their previous expected value
// write r0 (ignored), r1, then add r0,r1 while writing r2
1 00 12345678 00000000 00000004 00000000 00000004 00000000 00000000 00000000
1 01 00000005 00000000 00000008 00000000 00000008 00000000 00000000 00000000
1 02 FFFFFFF6 C0010001 0000000C C0010001 0000000C 00000000 00000005 00000000
// lw, addi, subi x2, slti, a compare inside the slti..snei range
1 03 FFFF0000 08250010 00000010 08250010 00000010 00000005 00000005 00000010
1 04 80000001 4046FFFC 00000014 4046FFFC 00000014 8000000A 00000005 80000004
0 00 00000000 48670007 00000018 48670007 00000018 80010000 00000005 80000007
0 00 00000000 4828FF00 0000001C 4828FF00 0000001C 00000005 00000005 00000100
0 00 00000000 68897FFF 00000020 68897FFF 00000020 FFFFFFFF 00000005 00007FFF
0 00 00000000 744A8001 00000024 744A8001 00000024 8000000A 00000005 80007FFF
// r-type add, sub x2, and, xor, slt, a compare inside the slt..sne range
0 00 00000000 C0430001 00000028 C0430001 00000028 8000000A 80010000 80007FFF
0 00 00000000 C0240003 0000002C C0240003 0000002C 00000005 7FFFFFFF 80007FFF
0 00 00000000 C0810003 00000030 C0810003 00000030 FFFFFFFF 80000005 80007FFF
0 00 00000000 C0430005 00000034 C0430005 00000034 FFFFFFF6 FFFF0000 80007FFF
0 00 00000000 C0820007 00000038 C0820007 00000038 80000001 FFFFFFF6 80007FFF
0 00 00000000 C064000B 0000003C C064000B 0000003C FFFF0000 80000001 80007FFF
0 00 00000000 C022000E 00000040 C022000E 00000040 00000005 FFFFFFF6 80007FFF
// sw, andi, beqz, j, bnez
0 00 00000000 28440020 00000044 28440020 00000044 8000000A 80000001 00000020
0 00 00000000 508BF0F0 00000048 508BF0F0 00000048 80000001 80000001 0000F0F0
0 00 00000000 80408004 0000004C 80408004 0000004C FFFFFFF6 80000001 00008004
0 00 00000000 92ABCDEF 00000050 92ABCDEF 00000050 FFFFFFF6 80000001 02ABCDEF
0 00 00000000 8460FFFF 00000054 8460FFFF 00000054 FFFF0000 80000001 0000FFFF
// write r1 and read it in the same cycle, then read it again
1 01 FFFFFF00 C0200001 00000058 C0200001 00000058 00000005 00000000 0000FFFF
0 00 00000000 C0200001 0000005C C0200001 0000005C 80000100 00000000 0000FFFF
// unknown opcode, unknown function code
0 00 00000000 FC221234 00000060 FC221234 00000060 80000100 00000000 0000FFFF
0 00 00000000 C083003F 00000064 C083003F 00000064 80000100 00000000 0000FFFF

/* id_stage.f */
+incdir+include
rtl/id_stage_pkg.sv
rtl/decode_ctrl_if.sv
rtl/register_file.sv
rtl/instr_classifier.sv
rtl/operand_stage.sv
rtl/id_stage.sv
dv/id_stage_properties.sv
dv/id_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the ID stage testbench with Verilator and run it from the project root.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module id_stage_tb \
  -f id_stage.f \
  --Mdir obj_dir \
  -o id_stage_sim

./obj_dir/id_stage_sim
